/* pc_trace_pkg.sv */
/*
 * shared types and constants for the pc trace port
 * address, state and character widths, fsm encodings, serial timing
 */
`default_nettype none

package pc_trace_pkg;

  // widths with a meaning
  typedef logic [19:0] addr_t;
  typedef logic [2:0]  cpu_st_t;
  typedef logic [3:0]  seg_t;
  typedef logic [7:0]  char_t;
  // wide enough to hold CLKS_PER_BIT itself
  typedef logic [3:0]  baud_cnt_t;

  // core state code for opcode fetch
  localparam cpu_st_t OPCODE_ST = 3'd0;

  // rom segments, never traced
  localparam seg_t ROM_SEG_HI = 4'hf;
  localparam seg_t ROM_SEG_LO = 4'hc;

  // serial timing
  localparam baud_cnt_t CLKS_PER_BIT = 4'd8;

  // five hex digits then a space per address
  localparam int    NUM_DIGITS = 5;
  localparam char_t SEP_CHAR   = 8'h20;

  typedef enum logic [1:0] {SEND_IDLE, SEND_LOAD, SEND_CHAR, SEND_WAIT} send_state_t;
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

/* tx_char_if.sv */
/*
 * character handoff between sequencer, baud timer and serial shifter
 */
`timescale 1ns/1ps
`default_nettype none

interface tx_char_if
  import pc_trace_pkg::*;
();

  char_t ch;    // character to frame
  logic  go;    // one cycle, starts a frame
  logic  busy;  // frame on the line
  logic  tick;  // bit boundary

  modport sender  (output ch, output go, input busy);
  modport shifter (input ch, input go, input tick, output busy);
  modport timer   (input busy, output tick);

endinterface

`default_nettype wire

/* trace_capture.sv */
/*
 * fetch address capture
 * flags fetch entries outside rom, latches the pc, runs request and block
 */
`timescale 1ns/1ps
`default_nettype none

module trace_capture
  import pc_trace_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,
  input  addr_t   pc,
  input  cpu_st_t zet_st,
  input  wire     send_ack,
  output addr_t   send_addr,
  output logic    send_stb,
  output logic    block
);

  cpu_st_t old_st;
  logic    new_pc;
  logic    pend;    // a send is owed, current or queued
  logic    op_st;
  logic    rom;
  seg_t    seg;

  assign seg   = pc[19:16];
  assign op_st = (zet_st == OPCODE_ST);
  assign rom   = (seg == ROM_SEG_HI) || (seg == ROM_SEG_LO);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      old_st   <= OPCODE_ST;
      new_pc   <= 1'b0;
      block    <= 1'b0;
      send_stb <= 1'b0;
      pend     <= 1'b0;
    end else begin
      old_st <= zet_st;
      // only a transition into fetch counts
      new_pc <= op_st && (zet_st != old_st) && !rom;

      // stall when a second address shows up before the ack
      if (new_pc)
        block <= pend && !send_ack;
      else if (send_ack)
        block <= 1'b0;

      // strobe drops for one cycle on every ack
      send_stb <= send_ack ? 1'b0 : (pend || new_pc);

      // stays set across the ack if an address is queued
      if (pend)
        pend <= send_ack ? (new_pc || block) : 1'b1;
      else
        pend <= new_pc;
    end
  end

  // core holds pc while blocked, so the ack reload picks up the queued one
  always_ff @(posedge clk) begin
    if ((new_pc && !pend) || send_ack)
      send_addr <= pc;
  end

endmodule

`default_nettype wire

/* addr_sender.sv */
/*
 * character sequencer
 * five hex digits then a space per request, ack after the last stop bit
 */
`timescale 1ns/1ps
`default_nettype none

module addr_sender
  import pc_trace_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n,
  input  addr_t        send_addr,
  input  wire          send_stb,
  output logic         send_ack,
  output logic         load,
  output logic         next,
  input  wire          last,
  input  char_t        digit_char,
  tx_char_if.sender    tx
);

  send_state_t state;
  logic        sep;         // separator phase
  logic        stb_q;
  addr_t       taken_addr;  // address of the request in progress
  logic        start;
  logic        frame_done;

  // new request, either a strobe edge or a fresh address
  assign start = send_stb && (!stb_q || (send_addr != taken_addr));

  // shifter raises busy on the edge that sees go, so idle in WAIT means done
  assign frame_done = (state == SEND_WAIT) && !tx.busy;

  assign load     = (state == SEND_LOAD);
  assign next     = frame_done && !sep && !last;
  assign send_ack = frame_done && sep;

  assign tx.go = (state == SEND_CHAR);
  assign tx.ch = sep ? SEP_CHAR : digit_char;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= SEND_IDLE;
      sep   <= 1'b0;
      stb_q <= 1'b0;
    end else begin
      stb_q <= send_stb;
      case (state)
        SEND_IDLE: begin
          if (start)
            state <= SEND_LOAD;
        end
        SEND_LOAD: begin
          // address shifter takes send_addr this cycle
          sep   <= 1'b0;
          state <= SEND_CHAR;
        end
        SEND_CHAR: begin
          state <= SEND_WAIT;
        end
        SEND_WAIT: begin
          if (!tx.busy) begin
            if (sep) begin
              sep   <= 1'b0;
              state <= SEND_IDLE;
            end else begin
              // fifth digit out, space goes next
              if (last)
                sep <= 1'b1;
              state <= SEND_CHAR;
            end
          end
        end
        default: state <= SEND_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SEND_LOAD)
      taken_addr <= send_addr;
  end

endmodule

`default_nettype wire

/* addr_shift.sv */
/*
 * address nibble shifter with hex to ascii conversion
 */
`timescale 1ns/1ps
`default_nettype none

module addr_shift
  import pc_trace_pkg::*;
(
  input  wire   clk,
  input  wire   rst_n,
  input  addr_t send_addr,
  input  wire   load,
  input  wire   next,
  output logic  last,
  output char_t digit_char
);

  addr_t      work;
  logic [2:0] digit_cnt;
  seg_t       nib;

  // most significant nibble first
  always_ff @(posedge clk) begin
    if (load)
      work <= send_addr;
    else if (next)
      work <= {work[15:0], 4'h0};
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      digit_cnt <= 3'd0;
    else if (load)
      digit_cnt <= 3'd0;
    else if (next)
      digit_cnt <= digit_cnt + 3'd1;
  end

  assign last = (digit_cnt == 3'(NUM_DIGITS - 1));
  assign nib  = work[19:16];

  // '0'..'9' then 'A'..'F', upper case
  assign digit_char = (nib < 4'd10) ? (8'h30 + {4'h0, nib}) : (8'h37 + {4'h0, nib});

endmodule

`default_nettype wire

/* baud_timer.sv */
/*
 * bit timer, one tick every CLKS_PER_BIT cycles while a frame runs
 */
`timescale 1ns/1ps
`default_nettype none

module baud_timer
  import pc_trace_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,
  tx_char_if.timer tx
);

  baud_cnt_t cnt;

  // held at zero between frames so each frame starts a full bit
  always_ff @(posedge clk) begin
    if (!rst_n)
      cnt <= '0;
    else if (!tx.busy)
      cnt <= '0;
    else if (cnt == CLKS_PER_BIT - 1'b1)
      cnt <= '0;
    else
      cnt <= cnt + 1'b1;
  end

  // last cycle of each bit
  assign tx.tick = tx.busy && (cnt == CLKS_PER_BIT - 1'b1);

endmodule

`default_nettype wire

/* uart_tx_shift.sv */
/*
 * 8N1 transmit shifter
 * start bit, eight data bits lsb first, stop bit
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_shift
  import pc_trace_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  tx_char_if.shifter tx,
  output logic       trx
);

  tx_state_t  state;
  logic [2:0] bit_cnt;
  char_t      sreg;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      bit_cnt <= 3'd0;
      tx.busy <= 1'b0;
      trx     <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (tx.go) begin
            trx     <= 1'b0;
            tx.busy <= 1'b1;
            state   <= TX_START;
          end
        end
        TX_START: begin
          if (tx.tick) begin
            trx     <= sreg[0];
            bit_cnt <= 3'd0;
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (tx.tick) begin
            if (bit_cnt == 3'd7) begin
              trx   <= 1'b1;
              state <= TX_STOP;
            end else begin
              trx     <= sreg[0];
              bit_cnt <= bit_cnt + 3'd1;
            end
          end
        end
        TX_STOP: begin
          // busy drops on the tick ending the stop bit
          if (tx.tick) begin
            tx.busy <= 1'b0;
            state   <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // data path, sreg[0] is always the next bit to drive
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && tx.go)
      sreg <= tx.ch;
    else if (tx.tick && (state == TX_START || state == TX_DATA))
      sreg <= {1'b0, sreg[7:1]};
  end

endmodule

`default_nettype wire

/* pc_trace.sv */
/*
 * pc trace port top
 * capture, sequencer, nibble shifter, bit timer and uart shifter
 */
`timescale 1ns/1ps
`default_nettype none

module pc_trace
  import pc_trace_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,
  input  addr_t   pc,
  input  cpu_st_t zet_st,
  output logic    block,
  output logic    trx
);

  addr_t send_addr;
  logic  send_stb;
  logic  send_ack;
  logic  load;
  logic  next;
  logic  last;
  char_t digit_char;

  tx_char_if u_tx_if ();

  trace_capture u_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .zet_st    (zet_st),
    .send_ack  (send_ack),
    .send_addr (send_addr),
    .send_stb  (send_stb),
    .block     (block)
  );

  addr_sender u_sender (
    .clk        (clk),
    .rst_n      (rst_n),
    .send_addr  (send_addr),
    .send_stb   (send_stb),
    .send_ack   (send_ack),
    .load       (load),
    .next       (next),
    .last       (last),
    .digit_char (digit_char),
    .tx         (u_tx_if.sender)
  );

  addr_shift u_addr_shift (
    .clk        (clk),
    .rst_n      (rst_n),
    .send_addr  (send_addr),
    .load       (load),
    .next       (next),
    .last       (last),
    .digit_char (digit_char)
  );

  baud_timer u_baud (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (u_tx_if.timer)
  );

  uart_tx_shift u_tx_shift (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (u_tx_if.shifter),
    .trx   (trx)
  );

endmodule

`default_nettype wire

/* pc_trace_tb.sv */
/*
 * testbench for the pc trace port
 * lfsr driven core model, serial receiver model, compare tasks
 */
`timescale 1ns/1ps
`default_nettype none

module pc_trace_tb
  import pc_trace_pkg::*;
();

  localparam int NUM_ADDRS      = 200;
  localparam int BIT_CLKS       = int'(CLKS_PER_BIT);
  localparam int TIMEOUT_CYCLES = NUM_ADDRS * 6 * 10 * BIT_CLKS + NUM_ADDRS * 150 + 1000;
  // ack trails the last stop bit sample by a cycle or two
  localparam int ACK_SLACK      = 3;

  logic        clk = 1'b0;
  logic        rst_n;
  addr_t       pc;
  cpu_st_t     zet_st;
  logic        block;
  logic        trx;

  logic [31:0] lfsr = 32'h94e4;
  addr_t       exp_q[$];        // qualified addresses not yet seen on trx
  int          cyc = 0;
  int          last_pop_cyc = -100;
  int          rx_count = 0;
  int          obs_cnt = 0;     // cycles until block answers the last entry
  logic        prev_blk = 1'b0;

  pc_trace u_pc_trace (
    .clk    (clk),
    .rst_n  (rst_n),
    .pc     (pc),
    .zet_st (zet_st),
    .block  (block),
    .trx    (trx)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d addresses received",
               cyc, rx_count, NUM_ADDRS);
      $display("TEST FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // nibble value of one digit, bit 4 set for anything but 0-9 and A-F
  function automatic logic [4:0] hex_value(char_t c);
    if (c >= 8'h30 && c <= 8'h39)
      return {1'b0, c[3:0]};
    if (c >= 8'h41 && c <= 8'h46)
      return {1'b0, c[3:0] + 4'd9};
    return 5'h10;
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_char(input char_t got, input char_t exp);
    if (got !== exp)
      report_error($sformatf("char got %h expected %h", got, exp));
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp);
    if (got !== exp)
      report_error($sformatf("address got %h expected %h", got, exp));
  endtask

  task automatic check_block(input logic exp);
    if (block !== exp)
      report_error($sformatf("block got %b expected %b", block, exp));
  endtask

  task automatic check_line(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // block may only rise two cycles after a qualifying entry
  task automatic watch_block();
    logic recent;
    logic obs;
    recent = (cyc - last_pop_cyc) <= ACK_SLACK;
    obs    = 1'b0;
    if (obs_cnt > 0) begin
      obs_cnt--;
      obs = (obs_cnt == 0);
    end
    if (obs && (exp_q.size() > 1 || !recent))
      check_block(exp_q.size() > 1);
    else if (block && !prev_blk && !obs)
      report_error("block rose without a new address");
    else if (block && exp_q.size() < 2 && !recent)
      report_error("block still high after the send finished");
    prev_blk = block;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    watch_block();
  endtask

  // n mid-cycle samples of one bit, all must agree
  task automatic read_bit(input int n, output logic b);
    logic first;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      if (i == 0)
        first = trx;
      else if (trx !== first)
        report_error("serial bit shorter than CLKS_PER_BIT cycles");
    end
    b = first;
  endtask

  task automatic rx_frame(output char_t ch);
    logic b;
    @(negedge clk);
    while (trx !== 1'b0)
      @(negedge clk);
    // half a cycle into the start bit here
    read_bit(BIT_CLKS - 1, b);
    check_line(b, 1'b0, "start bit");
    for (int i = 0; i < 8; i++) begin
      read_bit(BIT_CLKS, b);
      ch[i] = b;
    end
    read_bit(BIT_CLKS, b);
    check_line(b, 1'b1, "stop bit");
  endtask

  initial begin : serial_rx
    char_t      ch;
    addr_t      got_addr;
    logic [4:0] dv;
    int         digit;
    digit    = 0;
    got_addr = '0;
    wait (rst_n === 1'b1);
    forever begin
      rx_frame(ch);
      if (exp_q.size() == 0)
        report_error($sformatf("char %h on trx with no address expected", ch));
      if (digit < NUM_DIGITS) begin
        dv = hex_value(ch);
        if (dv[4])
          report_error($sformatf("char %h is not an upper case hex digit", ch));
        got_addr = {got_addr[15:0], dv[3:0]};
        digit++;
      end else begin
        // ascii space closes each address
        check_char(ch, 8'h20);
        check_addr(got_addr, exp_q[0]);
        void'(exp_q.pop_front());
        rx_count++;
        last_pop_cyc = cyc;
        digit        = 0;
      end
    end
  end

  initial begin : core_model
    logic [31:0] r;
    cpu_st_t     st;
    cpu_st_t     prev_st;
    addr_t       npc;
    logic        entry;
    int          hold;
    int          pushed;
    rst_n   = 1'b0;
    pc      = '0;
    zet_st  = OPCODE_ST;
    prev_st = OPCODE_ST;
    pushed  = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_line(trx, 1'b1, "trx after reset");
    check_block(1'b0);
    while (pushed < NUM_ADDRS) begin
      take_bits(3, r);
      st = r[2:0];
      take_bits(2, r);
      hold  = 2 + r[1:0];
      entry = (st == OPCODE_ST) && (prev_st != OPCODE_ST);
      npc   = pc;
      if (entry) begin
        take_bits(20, r);
        npc = r[19:0];
        take_bits(2, r);
        // roughly one entry in four lands in rom
        if (r[1:0] == 2'd0) begin
          take_bits(1, r);
          npc[19:16] = r[0] ? ROM_SEG_HI : ROM_SEG_LO;
        end
      end
      pc     = npc;
      zet_st = st;
      if (entry && npc[19:16] != ROM_SEG_HI && npc[19:16] != ROM_SEG_LO) begin
        exp_q.push_back(npc);
        pushed++;
        obs_cnt = 2;
      end
      prev_st = st;
      // the core stalls while block is high
      while (hold > 0) begin
        next_cycle();
        if (!block)
          hold--;
      end
    end
    zet_st = 3'd1;
    while (exp_q.size() > 0)
      next_cycle();
    repeat (ACK_SLACK) next_cycle();
    // no stray frames after the last address
    repeat (20 * BIT_CLKS) begin
      next_cycle();
      check_line(trx, 1'b1, "trx idle after last address");
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* pc_trace.f */
pc_trace_pkg.sv
tx_char_if.sv
trace_capture.sv
addr_sender.sv
addr_shift.sv
baud_timer.sv
uart_tx_shift.sv
pc_trace.sv
pc_trace_tb.sv
